//--- hw/tagbuf_pkg.sv
// Datapath widths, typedefs and cache geometry for the tagged capture buffer.
// Imported by the lookup, storage and top level blocks and by the testbench.

package tagbuf_pkg;

    localparam int DATA_W = 32;
    localparam int TAG_W  = 8;

    // Buffer geometry, 16 slots
    localparam int SLOT_W = 4;
    localparam int DEPTH  = 1 << SLOT_W;

    // Fully associative cache in front of the buffer
    localparam int WAYS  = 4;
    localparam int WAY_W = 2;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [SLOT_W-1:0] slot_t;
    typedef logic [WAY_W-1:0]  way_t;

    // Occupancy needs one bit more than a slot index to reach 16
    typedef logic [SLOT_W:0] count_t;

    typedef logic [WAY_W-1:0] age_t;

    // Age of a way right after a hit or a fill
    localparam age_t AGE_MAX = 2'd3;

endpackage

//--- hw/tagbuf_regs_pkg.sv
// APB register map of the capture buffer statistics block.
// Offsets, control bit positions and the counter type.

package tagbuf_regs_pkg;

    localparam int ADDR_W = 5;

    // Read-only registers
    localparam logic [ADDR_W-1:0] REG_STATUS = 5'h00;
    localparam logic [ADDR_W-1:0] REG_HITS   = 5'h04;
    localparam logic [ADDR_W-1:0] REG_MISSES = 5'h08;
    localparam logic [ADDR_W-1:0] REG_RATIO  = 5'h0C;

    // Write-only control, reads back as zero
    localparam logic [ADDR_W-1:0] REG_CTRL = 5'h10;

    localparam int CTRL_CLEAR_BIT = 0;
    localparam int CTRL_FLUSH_BIT = 1;

    typedef logic [31:0] stat_t;

endpackage

//--- hw/tag_match.sv
// Combinational tag lookup for the capture buffer.
// Matches the request tag against cache ways and buffer slots and picks the fill victim.

`timescale 1ns/1ps

module tag_match
    import tagbuf_pkg::*;
(
    input  tag_t             rd_tag,
    input  tag_t             way_tags   [WAYS],
    input  logic [WAYS-1:0]  way_valid,
    input  age_t             way_ages   [WAYS],
    input  tag_t             slot_tags  [DEPTH],
    input  logic [DEPTH-1:0] slot_used,
    output logic             hit,
    output way_t             hit_way,
    output logic             found,
    output slot_t            found_slot,
    output way_t             victim_way
);

    logic have_free;
    age_t min_age;
    logic dup_tag;

    // Ways hold distinct tags, so at most one can match
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_valid[w] && (way_tags[w] == rd_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    // Ascending scan, so the highest matching slot wins
    always_comb begin
        found      = 1'b0;
        found_slot = '0;
        for (int s = 0; s < DEPTH; s++) begin
            if (slot_used[s] && (slot_tags[s] == rd_tag)) begin
                found      = 1'b1;
                found_slot = slot_t'(s);
            end
        end
    end

    // Lowest invalid way first, else the oldest way with ties to the lowest index
    always_comb begin
        have_free  = 1'b0;
        victim_way = '0;
        min_age    = way_ages[0];
        for (int w = 0; w < WAYS; w++) begin
            if (!way_valid[w] && !have_free) begin
                have_free  = 1'b1;
                victim_way = way_t'(w);
            end
        end
        if (!have_free) begin
            for (int w = 1; w < WAYS; w++) begin
                if (way_ages[w] < min_age) begin
                    min_age    = way_ages[w];
                    victim_way = way_t'(w);
                end
            end
        end
    end

    // Fills only ever bring in a tag that missed, so valid tags stay unique
    always_comb begin
        dup_tag = 1'b0;
        for (int i = 0; i < WAYS; i++) begin
            for (int j = i + 1; j < WAYS; j++) begin
                if (way_valid[i] && way_valid[j] && (way_tags[i] == way_tags[j])) begin
                    dup_tag = 1'b1;
                end
            end
        end
        if (!$isunknown(way_valid)) begin
            assert (!dup_tag) else $error("two valid cache ways hold the same tag");
        end
    end

endmodule

//--- hw/line_store.sv
// Storage for the capture buffer: slot memories, write pointer, cache ways and LRU ages.
// Acts on the lookup results of tag_match and registers the read result one cycle later.

`timescale 1ns/1ps

module line_store
    import tagbuf_pkg::*;
(
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  data_t            wr_data,
    input  tag_t             wr_tag,
    input  logic             rd_en,
    input  logic             hit,
    input  way_t             hit_way,
    input  logic             found,
    input  slot_t            found_slot,
    input  way_t             victim_way,
    input  logic             flush,
    output logic             wr_ready,
    output logic             full,
    output logic             empty,
    output count_t           count,
    output logic             rd_valid,
    output logic             rd_hit,
    output logic             rd_found,
    output data_t            rd_data,
    output tag_t             way_tags   [WAYS],
    output logic [WAYS-1:0]  way_valid,
    output age_t             way_ages   [WAYS],
    output tag_t             slot_tags  [DEPTH],
    output logic [DEPTH-1:0] slot_used
);

    data_t           slot_data [DEPTH];
    data_t           way_data  [WAYS];
    slot_t           wr_ptr;
    logic            wr_accept;
    logic            do_fill;
    logic            touch;
    way_t            touch_way;
    logic [WAYS-1:0] wt_match;

    assign full     = (count == count_t'(DEPTH));
    assign empty    = (count == '0);
    assign wr_ready = !full;

    // A flush in the same cycle wins over a write or a fill
    assign wr_accept = wr_en && !full && !flush;
    assign do_fill   = rd_en && !hit && found && !flush;
    assign touch     = rd_en && (hit || found);
    assign touch_way = hit ? hit_way : victim_way;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            wt_match[w] = wr_accept && way_valid[w] && (way_tags[w] == wr_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            slot_data[wr_ptr] <= wr_data;
            slot_tags[wr_ptr] <= wr_tag;
        end
    end

    // Write-through first, a fill of the same way overrides it
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (wt_match[w]) begin
                way_data[w] <= wr_data;
            end
        end
        if (do_fill) begin
            way_data[victim_way] <= slot_data[found_slot];
            way_tags[victim_way] <= slot_tags[found_slot];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr    <= '0;
            count     <= '0;
            slot_used <= '0;
            way_valid <= '0;
            for (int w = 0; w < WAYS; w++) begin
                way_ages[w] <= '0;
            end
        end else if (flush) begin
            wr_ptr    <= '0;
            count     <= '0;
            slot_used <= '0;
            way_valid <= '0;
            for (int w = 0; w < WAYS; w++) begin
                way_ages[w] <= '0;
            end
        end else begin
            if (wr_accept) begin
                wr_ptr            <= wr_ptr + 1'b1;
                count             <= count + 1'b1;
                slot_used[wr_ptr] <= 1'b1;
            end
            if (do_fill) begin
                way_valid[victim_way] <= 1'b1;
            end
            // LRU aging on every hit or fill
            if (touch) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (way_t'(w) == touch_way) begin
                        way_ages[w] <= AGE_MAX;
                    end else if (way_ages[w] != '0) begin
                        way_ages[w] <= way_ages[w] - 1'b1;
                    end
                end
            end
        end
    end

    // Read result, data is zero whenever nothing was found
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
            rd_hit   <= 1'b0;
            rd_found <= 1'b0;
            rd_data  <= '0;
        end else begin
            rd_valid <= rd_en;
            rd_hit   <= rd_en && hit;
            rd_found <= rd_en && (hit || found);
            if (rd_en && hit) begin
                rd_data <= way_data[hit_way];
            end else if (rd_en && found) begin
                rd_data <= slot_data[found_slot];
            end else begin
                rd_data <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) count <= count_t'(DEPTH))
        else $error("buffer count above depth");

    assert property (@(posedge clk) disable iff (!rst_n)
        (wr_en && full && !flush) |=> (full && $stable(wr_ptr)))
        else $error("write accepted while full");

    assert property (@(posedge clk) disable iff (!rst_n) rd_en |=> rd_valid)
        else $error("read result missing one cycle after rd_en");

endmodule

//--- hw/stats_apb.sv
// Hit and miss statistics with an APB slave register map.
// Also decodes control writes into clear and flush pulses for the rest of the buffer.

`timescale 1ns/1ps

module stats_apb
    import tagbuf_regs_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    input  logic              rd_valid,
    input  logic              rd_hit,
    input  logic              full,
    input  logic              empty,
    input  logic [4:0]        count,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr,
    output logic              clear_stats,
    output logic              flush
);

    stat_t       hits;
    stat_t       misses;
    stat_t       hit_ratio;
    logic [32:0] total;
    logic [45:0] scaled;
    logic [45:0] quotient;
    logic        access;
    logic        ctrl_wr;
    logic        mapped;
    logic        read_only;

    assign pready = 1'b1;

    // Ratio in hundredths of a percent, rounded down
    assign total     = {1'b0, hits} + {1'b0, misses};
    assign scaled    = 46'(hits) * 46'd10000;
    assign quotient  = (total == '0) ? '0 : scaled / 46'(total);
    assign hit_ratio = stat_t'(quotient);

    always_comb begin
        mapped    = 1'b1;
        read_only = 1'b1;
        case (paddr)
            REG_STATUS, REG_HITS, REG_MISSES, REG_RATIO: read_only = 1'b1;
            REG_CTRL: read_only = 1'b0;
            default:  mapped = 1'b0;
        endcase
    end

    assign access  = psel && penable;
    assign pslverr = access && (!mapped || (pwrite && read_only));
    assign ctrl_wr = access && pwrite && (paddr == REG_CTRL);

    // Single-cycle pulses, the access phase lasts one cycle
    assign clear_stats = ctrl_wr && pwdata[CTRL_CLEAR_BIT];
    assign flush       = ctrl_wr && pwdata[CTRL_FLUSH_BIT];

    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (paddr)
                REG_STATUS: prdata = {19'd0, count, 6'd0, empty, full};
                REG_HITS:   prdata = hits;
                REG_MISSES: prdata = misses;
                REG_RATIO:  prdata = hit_ratio;
                default:    prdata = '0;
            endcase
        end
    end

    // A clear drops any result counted in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hits   <= '0;
            misses <= '0;
        end else if (clear_stats) begin
            hits   <= '0;
            misses <= '0;
        end else if (rd_valid) begin
            if (rd_hit) begin
                hits <= hits + 1'b1;
            end else begin
                misses <= misses + 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else $error("APB penable without psel");

endmodule

//--- hw/tagbuf_top.sv
// Top level of the tagged capture buffer with its lookup cache.
// Joins the tag lookup, the storage block and the APB statistics block.

`timescale 1ns/1ps

module tagbuf_top
    import tagbuf_pkg::*;
    import tagbuf_regs_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  data_t             wr_data,
    input  tag_t              wr_tag,
    output logic              wr_ready,
    input  logic              rd_en,
    input  tag_t              rd_tag,
    output logic              rd_valid,
    output logic              rd_hit,
    output logic              rd_found,
    output data_t             rd_data,
    output logic              full,
    output logic              empty,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    output logic [31:0]       prdata,
    output logic              pready,
    output logic              pslverr
);

    logic             hit;
    way_t             hit_way;
    logic             found;
    slot_t            found_slot;
    way_t             victim_way;
    logic             flush;
    count_t           count;
    tag_t             way_tags  [WAYS];
    logic [WAYS-1:0]  way_valid;
    age_t             way_ages  [WAYS];
    tag_t             slot_tags [DEPTH];
    logic [DEPTH-1:0] slot_used;

    tag_match i_tag_match (
        .rd_tag     (rd_tag),
        .way_tags   (way_tags),
        .way_valid  (way_valid),
        .way_ages   (way_ages),
        .slot_tags  (slot_tags),
        .slot_used  (slot_used),
        .hit        (hit),
        .hit_way    (hit_way),
        .found      (found),
        .found_slot (found_slot),
        .victim_way (victim_way)
    );

    line_store i_line_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .wr_data    (wr_data),
        .wr_tag     (wr_tag),
        .rd_en      (rd_en),
        .hit        (hit),
        .hit_way    (hit_way),
        .found      (found),
        .found_slot (found_slot),
        .victim_way (victim_way),
        .flush      (flush),
        .wr_ready   (wr_ready),
        .full       (full),
        .empty      (empty),
        .count      (count),
        .rd_valid   (rd_valid),
        .rd_hit     (rd_hit),
        .rd_found   (rd_found),
        .rd_data    (rd_data),
        .way_tags   (way_tags),
        .way_valid  (way_valid),
        .way_ages   (way_ages),
        .slot_tags  (slot_tags),
        .slot_used  (slot_used)
    );

    // The counter clear stays inside the statistics block
    stats_apb i_stats_apb (
        .clk         (clk),
        .rst_n       (rst_n),
        .paddr       (paddr),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .pwdata      (pwdata),
        .rd_valid    (rd_valid),
        .rd_hit      (rd_hit),
        .full        (full),
        .empty       (empty),
        .count       (count),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .clear_stats (),
        .flush       (flush)
    );

endmodule

//--- verif/tagbuf_checker.sv
// Scoreboard for the capture buffer testbench.
// Mirrors buffer, cache ways, LRU ages and counters from the DUT ports and reports mismatches.

`timescale 1ns/1ps

module tagbuf_checker
    import tagbuf_pkg::*;
    import tagbuf_regs_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              wr_en,
    input  data_t             wr_data,
    input  tag_t              wr_tag,
    input  logic              wr_ready,
    input  logic              rd_en,
    input  tag_t              rd_tag,
    input  logic              rd_valid,
    input  logic              rd_hit,
    input  logic              rd_found,
    input  data_t             rd_data,
    input  logic              full,
    input  logic              empty,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [31:0]       pwdata,
    input  logic [31:0]       prdata,
    input  logic              pready,
    input  logic              pslverr,
    input  logic [3:0]        test_id,
    input  logic [31:0]       exp_prdata,
    input  logic              exp_model,
    output int                value_errors,
    output int                other_errors
);

    tag_t       slot_tag  [DEPTH];
    data_t      slot_data [DEPTH];
    int         used;
    tag_t       way_tag   [WAYS];
    data_t      way_data  [WAYS];
    logic       way_valid [WAYS];
    int         way_age   [WAYS];
    longint     hits;
    longint     misses;
    logic       pend_valid;
    logic       pend_hit;
    logic       pend_found;
    data_t      pend_data;
    logic [3:0] pend_test;
    logic       ctrl_clear;
    logic       ctrl_flush;

    function automatic string test_name(logic [3:0] id);
        case (id)
            4'd1:    return "write_then_read";
            4'd2:    return "lru_replace";
            4'd3:    return "write_through";
            4'd4:    return "full_backpressure";
            4'd5:    return "apb_stats";
            4'd6:    return "flush";
            default: return "idle";
        endcase
    endfunction

    task automatic check_value(logic [3:0] id, string what, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            value_errors++;
            $display("FAIL %s %s: expected %h, actual %h", test_name(id), what, exp, act);
        end
    endtask

    // Expected register contents from the model
    function automatic logic [31:0] model_reg(logic [ADDR_W-1:0] addr);
        logic [31:0] status;
        status = 32'(used) << 8;
        if (used == 0) begin
            status[1] = 1'b1;
        end
        if (used == DEPTH) begin
            status[0] = 1'b1;
        end
        case (addr)
            REG_STATUS: return status;
            REG_HITS:   return 32'(hits);
            REG_MISSES: return 32'(misses);
            REG_RATIO:  return (hits + misses == 0) ? 32'd0 :
                               32'((hits * 64'd10000) / (hits + misses));
            default:    return 32'd0;
        endcase
    endfunction

    task automatic touch_way(int t);
        for (int w = 0; w < WAYS; w++) begin
            if (w == t) begin
                way_age[w] = int'(AGE_MAX);
            end else if (way_age[w] > 0) begin
                way_age[w]--;
            end
        end
    endtask

    // Lookup on the state before this edge, fills the cache on a buffer hit
    task automatic model_read(tag_t tag);
        int hw;
        int fs;
        int victim;
        hw = -1;
        fs = -1;
        victim = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (way_valid[w] && way_tag[w] == tag) begin
                hw = w;
            end
        end
        for (int s = 0; s < used; s++) begin
            if (slot_tag[s] == tag) begin
                fs = s;
            end
        end
        pend_valid = 1'b1;
        pend_test  = test_id;
        pend_hit   = (hw >= 0);
        pend_found = (hw >= 0) || (fs >= 0);
        pend_data  = '0;
        if (hw >= 0) begin
            pend_data = way_data[hw];
            touch_way(hw);
        end else if (fs >= 0) begin
            pend_data = slot_data[fs];
            for (int w = 0; w < WAYS; w++) begin
                if (!way_valid[w] && victim < 0) begin
                    victim = w;
                end
            end
            if (victim < 0) begin
                victim = 0;
                for (int w = 1; w < WAYS; w++) begin
                    if (way_age[w] < way_age[victim]) begin
                        victim = w;
                    end
                end
            end
            way_valid[victim] = 1'b1;
            way_tag[victim]   = tag;
            way_data[victim]  = slot_data[fs];
            touch_way(victim);
        end
    endtask

    task automatic check_apb();
        logic mapped;
        logic exp_err;
        mapped  = paddr inside {REG_STATUS, REG_HITS, REG_MISSES, REG_RATIO, REG_CTRL};
        exp_err = !mapped || (pwrite && paddr != REG_CTRL);
        if (!pwrite) begin
            check_value(test_id, "prdata", exp_model ? model_reg(paddr) : exp_prdata, prdata);
        end
        check_value(test_id, "pslverr", 32'(exp_err), 32'(pslverr));
        if (pwrite && paddr == REG_CTRL) begin
            ctrl_clear = pwdata[CTRL_CLEAR_BIT];
            ctrl_flush = pwdata[CTRL_FLUSH_BIT];
        end
    endtask

    task automatic clear_cache();
        used = 0;
        for (int w = 0; w < WAYS; w++) begin
            way_valid[w] = 1'b0;
            way_age[w]   = 0;
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clear_cache();
            hits       = 0;
            misses     = 0;
            pend_valid = 1'b0;
        end else begin
            ctrl_clear = 1'b0;
            ctrl_flush = 1'b0;
            // Result of the read sampled one edge earlier
            if (pend_valid && !rd_valid) begin
                other_errors++;
                $display("Read result missing one cycle after rd_en in %s", test_name(pend_test));
            end else if (!pend_valid && rd_valid) begin
                other_errors++;
                $display("Read result seen without a request in %s", test_name(test_id));
            end else if (pend_valid) begin
                check_value(pend_test, "rd_hit", 32'(pend_hit), 32'(rd_hit));
                check_value(pend_test, "rd_found", 32'(pend_found), 32'(rd_found));
                check_value(pend_test, "rd_data", pend_data, rd_data);
            end
            check_value(test_id, "full", 32'(used == DEPTH), 32'(full));
            check_value(test_id, "empty", 32'(used == 0), 32'(empty));
            check_value(test_id, "wr_ready", 32'(used < DEPTH), 32'(wr_ready));
            if (psel && !pready) begin
                other_errors++;
                $display("APB PREADY was low during a transfer in %s", test_name(test_id));
            end
            if (psel && penable) begin
                check_apb();
            end
            if (ctrl_clear) begin
                hits   = 0;
                misses = 0;
            end else if (pend_valid && pend_hit) begin
                hits++;
            end else if (pend_valid) begin
                misses++;
            end
            pend_valid = 1'b0;
            if (rd_en) begin
                model_read(rd_tag);
            end
            if (wr_en && used < DEPTH && !ctrl_flush) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (way_valid[w] && way_tag[w] == wr_tag) begin
                        way_data[w] = wr_data;
                    end
                end
                slot_tag[used]  = wr_tag;
                slot_data[used] = wr_data;
                used++;
            end
            if (ctrl_flush) begin
                clear_cache();
            end
        end
    end

endmodule

//--- verif/tagbuf_tb.sv
// Testbench top for the tagged capture buffer.
// Builds a stimulus table, applies one entry per cycle and leaves comparisons to tagbuf_checker.

`timescale 1ns/1ps

module tagbuf_tb
    import tagbuf_pkg::*;
    import tagbuf_regs_pkg::*;
();

    typedef enum logic [2:0] {OP_IDLE, OP_WRITE, OP_READ, OP_APB_RD, OP_APB_WR} op_e;

    typedef struct packed {
        op_e               op;
        logic [3:0]        test;
        tag_t              tag;
        data_t             data;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       exp;
        logic              exp_model;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic              wr_en;
    data_t             wr_data;
    tag_t              wr_tag;
    logic              wr_ready;
    logic              rd_en;
    tag_t              rd_tag;
    logic              rd_valid;
    logic              rd_hit;
    logic              rd_found;
    data_t             rd_data;
    logic              full;
    logic              empty;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    logic [31:0]       pwdata;
    logic [31:0]       prdata;
    logic              pready;
    logic              pslverr;
    logic [3:0]        test_id;
    logic [31:0]       exp_prdata;
    logic              exp_model;
    logic [3:0]        cur_test;
    entry_t            table_q [$];
    int                cycle_count;
    int                cycle_limit;
    int                value_errors;
    int                other_errors;

    always #5 clk = ~clk;

    tagbuf_top i_tagbuf_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .wr_data  (wr_data),
        .wr_tag   (wr_tag),
        .wr_ready (wr_ready),
        .rd_en    (rd_en),
        .rd_tag   (rd_tag),
        .rd_valid (rd_valid),
        .rd_hit   (rd_hit),
        .rd_found (rd_found),
        .rd_data  (rd_data),
        .full     (full),
        .empty    (empty),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    tagbuf_checker i_tagbuf_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .wr_tag       (wr_tag),
        .wr_ready     (wr_ready),
        .rd_en        (rd_en),
        .rd_tag       (rd_tag),
        .rd_valid     (rd_valid),
        .rd_hit       (rd_hit),
        .rd_found     (rd_found),
        .rd_data      (rd_data),
        .full         (full),
        .empty        (empty),
        .paddr        (paddr),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .test_id      (test_id),
        .exp_prdata   (exp_prdata),
        .exp_model    (exp_model),
        .value_errors (value_errors),
        .other_errors (other_errors)
    );

    task automatic push_entry(op_e op, tag_t tag, data_t data, logic [ADDR_W-1:0] addr,
                              logic [31:0] exp, logic model);
        entry_t e;
        e.op        = op;
        e.test      = cur_test;
        e.tag       = tag;
        e.data      = data;
        e.addr      = addr;
        e.exp       = exp;
        e.exp_model = model;
        table_q.push_back(e);
    endtask

    task automatic write_tag(tag_t tag);
        push_entry(OP_WRITE, tag, data_t'($urandom()), '0, '0, 1'b0);
    endtask

    task automatic read_tag(tag_t tag);
        push_entry(OP_READ, tag, '0, '0, '0, 1'b0);
    endtask

    task automatic apb_read(logic [ADDR_W-1:0] addr, logic [31:0] exp, logic model);
        push_entry(OP_APB_RD, '0, '0, addr, exp, model);
    endtask

    task automatic apb_write(logic [ADDR_W-1:0] addr, logic [31:0] data);
        push_entry(OP_APB_WR, '0, data, addr, '0, 1'b0);
    endtask

    task automatic idle_cycles(int n);
        for (int i = 0; i < n; i++) begin
            push_entry(OP_IDLE, '0, '0, '0, '0, 1'b0);
        end
    endtask

    task automatic build_table();
        // Write then read, miss with fill and then a hit
        cur_test = 4'd1;
        write_tag(8'h11);
        read_tag(8'h11);
        read_tag(8'h11);
        // Fill all ways, touch ways 0, 2 and 3, then evict way 1
        cur_test = 4'd2;
        write_tag(8'h21);
        write_tag(8'h22);
        write_tag(8'h23);
        read_tag(8'h21);
        read_tag(8'h22);
        read_tag(8'h23);
        read_tag(8'h11);
        read_tag(8'h22);
        read_tag(8'h23);
        write_tag(8'h24);
        read_tag(8'h24);
        read_tag(8'h11);
        read_tag(8'h22);
        read_tag(8'h23);
        read_tag(8'h24);
        read_tag(8'h21);
        // New data for a cached tag, then a tag that was never written
        cur_test = 4'd3;
        write_tag(8'h22);
        read_tag(8'h22);
        read_tag(8'h7F);
        // Six slots used so far and ten more fill the buffer
        cur_test = 4'd4;
        for (int i = 0; i < 10; i++) begin
            write_tag(tag_t'(8'h40 + i));
        end
        write_tag(8'h4A);
        read_tag(8'h4A);
        apb_read(REG_STATUS, 32'h0000_1001, 1'b0);
        cur_test = 4'd5;
        // One more hit leaves the ratio with a fraction above one half
        read_tag(8'h22);
        apb_read(REG_HITS, '0, 1'b1);
        apb_read(REG_MISSES, '0, 1'b1);
        apb_read(REG_RATIO, '0, 1'b1);
        apb_write(REG_CTRL, 32'h1 << CTRL_CLEAR_BIT);
        apb_read(REG_HITS, 32'd0, 1'b0);
        apb_read(REG_MISSES, 32'd0, 1'b0);
        apb_read(REG_RATIO, 32'd0, 1'b0);
        cur_test = 4'd6;
        apb_write(REG_CTRL, 32'h1 << CTRL_FLUSH_BIT);
        // Tag 8'h23 sits in the cache until the flush
        read_tag(8'h23);
        read_tag(8'h40);
        apb_read(REG_STATUS, 32'h0000_0002, 1'b0);
        apb_read(5'h14, 32'd0, 1'b0);
        apb_write(REG_HITS, 32'd0);
        write_tag(8'h11);
        read_tag(8'h11);
        idle_cycles(3);
    endtask

    // APB entries take a setup cycle and an access cycle
    task automatic apply_entry(entry_t e);
        @(posedge clk);
        wr_en   <= 1'b0;
        rd_en   <= 1'b0;
        psel    <= 1'b0;
        penable <= 1'b0;
        test_id <= e.test;
        case (e.op)
            OP_WRITE: begin
                wr_en   <= 1'b1;
                wr_tag  <= e.tag;
                wr_data <= e.data;
            end
            OP_READ: begin
                rd_en  <= 1'b1;
                rd_tag <= e.tag;
            end
            OP_APB_RD, OP_APB_WR: begin
                psel       <= 1'b1;
                paddr      <= e.addr;
                pwrite     <= (e.op == OP_APB_WR);
                pwdata     <= e.data;
                exp_prdata <= e.exp;
                exp_model  <= e.exp_model;
            end
            default: begin
            end
        endcase
        if (e.op inside {OP_APB_RD, OP_APB_WR}) begin
            @(posedge clk);
            penable <= 1'b1;
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    initial begin
        wait (cycle_limit > 0 && cycle_count >= cycle_limit);
        $display("Timeout: stimulus did not complete within %0d cycles", cycle_limit);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h3592_decd));
        clk         = 1'b0;
        rst_n       = 1'b0;
        wr_en       = 1'b0;
        wr_data     = '0;
        wr_tag      = '0;
        rd_en       = 1'b0;
        rd_tag      = '0;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        test_id     = '0;
        exp_prdata  = '0;
        exp_model   = 1'b0;
        cycle_count = 0;
        cur_test    = '0;
        build_table();
        cycle_limit = 20;
        foreach (table_q[i]) begin
            cycle_limit += (table_q[i].op inside {OP_APB_RD, OP_APB_WR}) ? 2 : 1;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end
        @(negedge clk);
        $display("Errors: %0d wrong values, %0d other failures", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
hw/tagbuf_pkg.sv
hw/tagbuf_regs_pkg.sv
hw/tag_match.sv
hw/line_store.sv
hw/stats_apb.sv
hw/tagbuf_top.sv
verif/tagbuf_checker.sv
verif/tagbuf_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tagbuf_tb -f verilog.f -o tagbuf_sim

./obj_dir/tagbuf_sim > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
    exit 1
fi
exit 0
